// File: build.f
source/cpu_isa_pkg.sv
source/cpu_pipe_pkg.sv
source/fetch_stage.sv
source/decode_stage.sv
source/forward_unit.sv
source/execute_stage.sv
source/memory_stage.sv
source/mips_core.sv
tests/clock_gen.sv
tests/tb_mips_core.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Compile the testbench with Verilator and run it; exit status follows the simulation
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_mips_core -f build.f -o sim_tb \
    && ./obj_dir/sim_tb \
    || { echo "Simulation did not pass"; exit 1; }

// File: source/cpu_isa_pkg.sv
package cpu_isa_pkg;

    // Architectural widths
    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [15:0] imm_t;
    typedef logic [4:0]  shamt_t;

    // Primary opcodes, instr[31:26]
    localparam logic [5:0] OP_RTYPE = 6'h00;
    localparam logic [5:0] OP_J     = 6'h02;
    localparam logic [5:0] OP_BEQ   = 6'h04;
    localparam logic [5:0] OP_BNE   = 6'h05;
    localparam logic [5:0] OP_ADDI  = 6'h08;
    localparam logic [5:0] OP_ANDI  = 6'h0C;
    localparam logic [5:0] OP_ORI   = 6'h0D;
    localparam logic [5:0] OP_LW    = 6'h23;
    localparam logic [5:0] OP_SW    = 6'h2B;

    // R-type funct field, instr[5:0]
    localparam logic [5:0] FN_SLL = 6'h00;
    localparam logic [5:0] FN_SRL = 6'h02;
    localparam logic [5:0] FN_ADD = 6'h20;
    localparam logic [5:0] FN_SUB = 6'h22;
    localparam logic [5:0] FN_AND = 6'h24;
    localparam logic [5:0] FN_OR  = 6'h25;
    localparam logic [5:0] FN_XOR = 6'h26;
    localparam logic [5:0] FN_NOR = 6'h27;
    localparam logic [5:0] FN_SLT = 6'h2A;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_NOR,
        ALU_SLT,
        ALU_SLL,
        ALU_SRL
    } alu_op_e;

endpackage

// File: source/cpu_pipe_pkg.sv
package cpu_pipe_pkg;

    import cpu_isa_pkg::*;

    // Memory depths in words
    localparam int IMEM_WORDS = 64;
    localparam int DMEM_WORDS = 16;

    typedef logic [5:0] imem_addr_t;
    typedef logic [3:0] dmem_addr_t;

    // ALU class from the main decoder, refined by funct or opcode in EX
    localparam logic [1:0] CLS_ADD   = 2'd0;
    localparam logic [1:0] CLS_SUB   = 2'd1;
    localparam logic [1:0] CLS_FUNCT = 2'd2;
    localparam logic [1:0] CLS_LOGIC = 2'd3;

    typedef enum logic [1:0] {
        FWD_NONE,
        FWD_EXMEM,
        FWD_MEMWB
    } fwd_sel_e;

    typedef struct packed {
        logic       reg_write;
        logic       mem_to_reg;
        logic       mem_read;
        logic       mem_write;
        logic       branch;
        logic       nbranch;
        logic       jump;
        logic       reg_dst;
        logic       alu_src;
        logic       zero_ext;
        logic [1:0] alu_class;
    } ctrl_t;

    typedef struct packed {
        word_t pc4;
        word_t instr;
    } if_id_t;

    typedef struct packed {
        ctrl_t     ctrl;
        word_t     pc4;
        word_t     instr;
        word_t     rs_data;
        word_t     rt_data;
        word_t     imm_ext;
        reg_addr_t rs;
        reg_addr_t rt;
        reg_addr_t rd;
    } id_ex_t;

    typedef struct packed {
        ctrl_t     ctrl;
        word_t     branch_target;
        logic      zero;
        word_t     alu_result;
        word_t     store_data;
        reg_addr_t dest;
    } ex_mem_t;

    typedef struct packed {
        logic      we;
        reg_addr_t dest;
        word_t     data;
    } wb_write_t;

    typedef struct packed {
        logic  valid;
        word_t target;
    } redirect_t;

endpackage

// File: source/decode_stage.sv
`timescale 1ns/1ps

module decode_stage (
    input  logic                     clk,
    input  logic                     i_rst,
    input  cpu_pipe_pkg::if_id_t     i_if_id,
    input  cpu_pipe_pkg::wb_write_t  i_wb,
    input  cpu_isa_pkg::reg_addr_t   i_dbg_reg,
    output cpu_pipe_pkg::id_ex_t     o_id_ex,
    output cpu_isa_pkg::word_t       o_dbg_reg_data
);

    import cpu_isa_pkg::*;
    import cpu_pipe_pkg::*;

    word_t      regs [32];
    ctrl_t      ctrl;
    logic [5:0] opcode;
    reg_addr_t  rs;
    reg_addr_t  rt;
    reg_addr_t  rd;
    imm_t       imm;
    word_t      imm_ext;
    word_t      rs_data;
    word_t      rt_data;

    // Same-cycle write from WB is seen by the readers
    function automatic word_t read_reg(input reg_addr_t idx, input word_t rf_val,
                                       input wb_write_t wb);
        if (wb.we && wb.dest != '0 && wb.dest == idx) begin
            return wb.data;
        end
        return rf_val;
    endfunction

    assign opcode = i_if_id.instr[31:26];
    assign rs     = i_if_id.instr[25:21];
    assign rt     = i_if_id.instr[20:16];
    assign rd     = i_if_id.instr[15:11];
    assign imm    = i_if_id.instr[15:0];

    //////////////////////////////
    // Main decoder
    //////////////////////////////
    always_comb begin
        ctrl = '0;
        case (opcode)
            OP_RTYPE: begin
                ctrl.reg_write = 1'b1;
                ctrl.reg_dst   = 1'b1;
                ctrl.alu_class = CLS_FUNCT;
            end
            OP_ADDI: begin
                ctrl.reg_write = 1'b1;
                ctrl.alu_src   = 1'b1;
                ctrl.alu_class = CLS_ADD;
            end
            OP_ANDI, OP_ORI: begin
                ctrl.reg_write = 1'b1;
                ctrl.alu_src   = 1'b1;
                ctrl.zero_ext  = 1'b1;
                ctrl.alu_class = CLS_LOGIC;
            end
            OP_LW: begin
                ctrl.reg_write  = 1'b1;
                ctrl.mem_to_reg = 1'b1;
                ctrl.mem_read   = 1'b1;
                ctrl.alu_src    = 1'b1;
                ctrl.alu_class  = CLS_ADD;
            end
            OP_SW: begin
                ctrl.mem_write = 1'b1;
                ctrl.alu_src   = 1'b1;
                ctrl.alu_class = CLS_ADD;
            end
            OP_BEQ: begin
                ctrl.branch    = 1'b1;
                ctrl.alu_class = CLS_SUB;
            end
            OP_BNE: begin
                ctrl.nbranch   = 1'b1;
                ctrl.alu_class = CLS_SUB;
            end
            OP_J:    ctrl.jump = 1'b1;
            default: ctrl = '0;
        endcase
    end

    assign imm_ext = ctrl.zero_ext ? {16'b0, imm} : {{16{imm[15]}}, imm};

    //////////////////////////////
    // Register file
    //////////////////////////////
    always_ff @(posedge clk) begin
        if (i_rst) begin
            regs <= '{default: '0};
        end else if (i_wb.we && i_wb.dest != '0) begin
            regs[i_wb.dest] <= i_wb.data;
        end
    end

    assign rs_data        = read_reg(rs, regs[rs], i_wb);
    assign rt_data        = read_reg(rt, regs[rt], i_wb);
    assign o_dbg_reg_data = read_reg(i_dbg_reg, regs[i_dbg_reg], i_wb);

    // ID/EX register
    always_ff @(posedge clk) begin
        if (i_rst) begin
            o_id_ex <= '0;
        end else begin
            o_id_ex.ctrl    <= ctrl;
            o_id_ex.pc4     <= i_if_id.pc4;
            o_id_ex.instr   <= i_if_id.instr;
            o_id_ex.rs_data <= rs_data;
            o_id_ex.rt_data <= rt_data;
            o_id_ex.imm_ext <= imm_ext;
            o_id_ex.rs      <= rs;
            o_id_ex.rt      <= rt;
            o_id_ex.rd      <= rd;
        end
    end

    // r0 stays zero through reset and any WB write aimed at it
    a_r0_zero: assert property (@(posedge clk) disable iff (i_rst)
        (rs == '0) |-> (rs_data == '0));

endmodule

// File: source/execute_stage.sv
`timescale 1ns/1ps

module execute_stage (
    input  logic                    clk,
    input  logic                    i_rst,
    input  cpu_pipe_pkg::id_ex_t    i_id_ex,
    input  cpu_pipe_pkg::wb_write_t i_wb,
    output cpu_pipe_pkg::ex_mem_t   o_ex_mem,
    output cpu_pipe_pkg::redirect_t o_jump
);

    import cpu_isa_pkg::*;
    import cpu_pipe_pkg::*;

    fwd_sel_e   fwd_a;
    fwd_sel_e   fwd_b;
    word_t      op_a;
    word_t      rt_val;
    word_t      op_b;
    word_t      alu_y;
    alu_op_e    alu_op;
    logic [5:0] opcode;
    logic [5:0] funct;
    shamt_t     shamt;

    function automatic word_t fwd_mux(input fwd_sel_e sel, input word_t reg_val,
                                      input word_t exmem_val, input word_t memwb_val);
        case (sel)
            FWD_EXMEM: return exmem_val;
            FWD_MEMWB: return memwb_val;
            default:   return reg_val;
        endcase
    endfunction

    forward_unit u_forward_unit (
        .i_rs     (i_id_ex.rs),
        .i_rt     (i_id_ex.rt),
        .i_ex_mem (o_ex_mem),
        .i_wb     (i_wb),
        .o_fwd_a  (fwd_a),
        .o_fwd_b  (fwd_b)
    );

    assign opcode = i_id_ex.instr[31:26];
    assign funct  = i_id_ex.instr[5:0];
    assign shamt  = i_id_ex.instr[10:6];

    //////////////////////////////
    // Operands
    //////////////////////////////
    assign op_a   = fwd_mux(fwd_a, i_id_ex.rs_data, o_ex_mem.alu_result, i_wb.data);
    assign rt_val = fwd_mux(fwd_b, i_id_ex.rt_data, o_ex_mem.alu_result, i_wb.data);
    assign op_b   = i_id_ex.ctrl.alu_src ? i_id_ex.imm_ext : rt_val;

    // ALU control
    always_comb begin
        alu_op = ALU_ADD;
        case (i_id_ex.ctrl.alu_class)
            CLS_SUB:   alu_op = ALU_SUB;
            CLS_LOGIC: alu_op = (opcode == OP_ANDI) ? ALU_AND : ALU_OR;
            CLS_FUNCT: begin
                case (funct)
                    FN_SUB:  alu_op = ALU_SUB;
                    FN_AND:  alu_op = ALU_AND;
                    FN_OR:   alu_op = ALU_OR;
                    FN_XOR:  alu_op = ALU_XOR;
                    FN_NOR:  alu_op = ALU_NOR;
                    FN_SLT:  alu_op = ALU_SLT;
                    FN_SLL:  alu_op = ALU_SLL;
                    FN_SRL:  alu_op = ALU_SRL;
                    FN_ADD:  alu_op = ALU_ADD;
                    default: alu_op = ALU_ADD;
                endcase
            end
            default:   alu_op = ALU_ADD;
        endcase
    end

    // Shifts act on rt by shamt
    always_comb begin
        case (alu_op)
            ALU_ADD: alu_y = op_a + op_b;
            ALU_SUB: alu_y = op_a - op_b;
            ALU_AND: alu_y = op_a & op_b;
            ALU_OR:  alu_y = op_a | op_b;
            ALU_XOR: alu_y = op_a ^ op_b;
            ALU_NOR: alu_y = ~(op_a | op_b);
            ALU_SLT: alu_y = word_t'($signed(op_a) < $signed(op_b));
            ALU_SLL: alu_y = op_b << shamt;
            ALU_SRL: alu_y = op_b >> shamt;
            default: alu_y = '0;
        endcase
    end

    //////////////////////////////
    // Jump redirect and EX/MEM
    //////////////////////////////
    assign o_jump.valid  = i_id_ex.ctrl.jump;
    assign o_jump.target = {i_id_ex.pc4[31:28], i_id_ex.instr[25:0], 2'b00};

    always_ff @(posedge clk) begin
        if (i_rst) begin
            o_ex_mem <= '0;
        end else begin
            o_ex_mem.ctrl          <= i_id_ex.ctrl;
            o_ex_mem.branch_target <= i_id_ex.pc4 + (i_id_ex.imm_ext << 2);
            o_ex_mem.zero          <= (alu_y == '0);
            o_ex_mem.alu_result    <= alu_y;
            o_ex_mem.store_data    <= rt_val;
            o_ex_mem.dest          <= i_id_ex.ctrl.reg_dst ? i_id_ex.rd : i_id_ex.rt;
        end
    end

endmodule

// File: source/fetch_stage.sv
`timescale 1ns/1ps

module fetch_stage (
    input  logic                    clk,
    input  logic                    i_rst,
    input  logic                    i_imem_we,
    input  cpu_pipe_pkg::imem_addr_t i_imem_addr,
    input  cpu_isa_pkg::word_t      i_imem_data,
    input  cpu_pipe_pkg::redirect_t i_jump,
    input  cpu_pipe_pkg::redirect_t i_branch,
    output cpu_pipe_pkg::if_id_t    o_if_id,
    output cpu_isa_pkg::word_t      o_pc
);

    import cpu_isa_pkg::*;
    import cpu_pipe_pkg::*;

    word_t      imem [IMEM_WORDS];
    word_t      pc;
    word_t      pc4;
    word_t      pc_next;
    imem_addr_t fetch_idx;

    //////////////////////////////
    // Program counter
    //////////////////////////////
    assign pc4 = pc + 32'd4;

    // Branch from MEM wins over jump from EX
    always_comb begin
        if (i_branch.valid) begin
            pc_next = i_branch.target;
        end else if (i_jump.valid) begin
            pc_next = i_jump.target;
        end else begin
            pc_next = pc4;
        end
    end

    always_ff @(posedge clk) begin
        if (i_rst) begin
            pc <= '0;
        end else begin
            pc <= pc_next;
        end
    end

    //////////////////////////////
    // Instruction memory
    //////////////////////////////
    always_ff @(posedge clk) begin
        if (i_imem_we) begin
            imem[i_imem_addr] <= i_imem_data;
        end
    end

    // Word index, wraps modulo depth
    assign fetch_idx = pc[7:2];

    always_ff @(posedge clk) begin
        if (i_rst) begin
            o_if_id <= '0;
        end else begin
            o_if_id.pc4   <= pc4;
            o_if_id.instr <= imem[fetch_idx];
        end
    end

    assign o_pc = pc;

    // Redirect targets from EX and MEM must keep the PC on a word boundary
    a_pc_aligned: assert property (@(posedge clk) disable iff (i_rst) pc[1:0] == 2'b00);

endmodule

// File: source/forward_unit.sv
`timescale 1ns/1ps

module forward_unit (
    input  cpu_isa_pkg::reg_addr_t  i_rs,
    input  cpu_isa_pkg::reg_addr_t  i_rt,
    input  cpu_pipe_pkg::ex_mem_t   i_ex_mem,
    input  cpu_pipe_pkg::wb_write_t i_wb,
    output cpu_pipe_pkg::fwd_sel_e  o_fwd_a,
    output cpu_pipe_pkg::fwd_sel_e  o_fwd_b
);

    import cpu_pipe_pkg::*;

    logic exmem_live;
    logic memwb_live;

    // Only a real write to a nonzero register is worth forwarding
    assign exmem_live = i_ex_mem.ctrl.reg_write && (i_ex_mem.dest != '0);
    assign memwb_live = i_wb.we && (i_wb.dest != '0);

    // Nearer producer first
    always_comb begin
        o_fwd_a = FWD_NONE;
        if (exmem_live && i_ex_mem.dest == i_rs) begin
            o_fwd_a = FWD_EXMEM;
        end else if (memwb_live && i_wb.dest == i_rs) begin
            o_fwd_a = FWD_MEMWB;
        end

        o_fwd_b = FWD_NONE;
        if (exmem_live && i_ex_mem.dest == i_rt) begin
            o_fwd_b = FWD_EXMEM;
        end else if (memwb_live && i_wb.dest == i_rt) begin
            o_fwd_b = FWD_MEMWB;
        end
    end

endmodule

// File: source/memory_stage.sv
`timescale 1ns/1ps

module memory_stage (
    input  logic                     clk,
    input  logic                     i_rst,
    input  cpu_pipe_pkg::ex_mem_t    i_ex_mem,
    input  cpu_pipe_pkg::dmem_addr_t i_dbg_mem_addr,
    output cpu_pipe_pkg::redirect_t  o_branch,
    output cpu_pipe_pkg::wb_write_t  o_wb,
    output cpu_isa_pkg::word_t       o_dbg_mem_data
);

    import cpu_isa_pkg::*;
    import cpu_pipe_pkg::*;

    word_t      dmem [DMEM_WORDS];
    dmem_addr_t mem_idx;
    word_t      rd_data;

    // MEM/WB register
    logic       wb_we;
    logic       wb_to_reg;
    reg_addr_t  wb_dest;
    word_t      wb_alu;
    word_t      wb_mem;

    //////////////////////////////
    // Data memory
    //////////////////////////////
    assign mem_idx = i_ex_mem.alu_result[5:2];

    always_ff @(posedge clk) begin
        if (i_ex_mem.ctrl.mem_write) begin
            dmem[mem_idx] <= i_ex_mem.store_data;
        end
    end

    assign rd_data        = dmem[mem_idx];
    assign o_dbg_mem_data = dmem[i_dbg_mem_addr];

    // beq on equal, bne on not equal
    assign o_branch.valid  = (i_ex_mem.ctrl.branch && i_ex_mem.zero)
                          || (i_ex_mem.ctrl.nbranch && !i_ex_mem.zero);
    assign o_branch.target = i_ex_mem.branch_target;

    always_ff @(posedge clk) begin
        if (i_rst) begin
            wb_we     <= 1'b0;
            wb_to_reg <= 1'b0;
            wb_dest   <= '0;
            wb_alu    <= '0;
            wb_mem    <= '0;
        end else begin
            wb_we     <= i_ex_mem.ctrl.reg_write;
            wb_to_reg <= i_ex_mem.ctrl.mem_to_reg;
            wb_dest   <= i_ex_mem.dest;
            wb_alu    <= i_ex_mem.alu_result;
            wb_mem    <= rd_data;
        end
    end

    // Write-back select
    assign o_wb.we   = wb_we;
    assign o_wb.dest = wb_dest;
    assign o_wb.data = wb_to_reg ? wb_mem : wb_alu;

    // Decoder never asks for a load and a store in one instruction
    a_no_rd_wr: assert property (@(posedge clk) disable iff (i_rst)
        !(i_ex_mem.ctrl.mem_read && i_ex_mem.ctrl.mem_write));

endmodule

// File: source/mips_core.sv
`timescale 1ns/1ps

module mips_core (
    input  logic                     clk,
    input  logic                     i_rst,
    input  logic                     i_imem_we,
    input  cpu_pipe_pkg::imem_addr_t i_imem_addr,
    input  cpu_isa_pkg::word_t       i_imem_data,
    input  cpu_isa_pkg::reg_addr_t   i_dbg_reg,
    input  cpu_pipe_pkg::dmem_addr_t i_dbg_mem_addr,
    output cpu_isa_pkg::word_t       o_pc,
    output cpu_isa_pkg::word_t       o_dbg_reg_data,
    output cpu_isa_pkg::word_t       o_dbg_mem_data
);

    import cpu_pipe_pkg::*;

    if_id_t    if_id;
    id_ex_t    id_ex;
    ex_mem_t   ex_mem;
    wb_write_t wb;
    redirect_t jump;
    redirect_t branch;

    fetch_stage u_fetch_stage (
        .clk         (clk),
        .i_rst       (i_rst),
        .i_imem_we   (i_imem_we),
        .i_imem_addr (i_imem_addr),
        .i_imem_data (i_imem_data),
        .i_jump      (jump),
        .i_branch    (branch),
        .o_if_id     (if_id),
        .o_pc        (o_pc)
    );

    decode_stage u_decode_stage (
        .clk            (clk),
        .i_rst          (i_rst),
        .i_if_id        (if_id),
        .i_wb           (wb),
        .i_dbg_reg      (i_dbg_reg),
        .o_id_ex        (id_ex),
        .o_dbg_reg_data (o_dbg_reg_data)
    );

    execute_stage u_execute_stage (
        .clk      (clk),
        .i_rst    (i_rst),
        .i_id_ex  (id_ex),
        .i_wb     (wb),
        .o_ex_mem (ex_mem),
        .o_jump   (jump)
    );

    memory_stage u_memory_stage (
        .clk            (clk),
        .i_rst          (i_rst),
        .i_ex_mem       (ex_mem),
        .i_dbg_mem_addr (i_dbg_mem_addr),
        .o_branch       (branch),
        .o_wb           (wb),
        .o_dbg_mem_data (o_dbg_mem_data)
    );

endmodule

// File: tests/clock_gen.sv
`timescale 1ns/1ps

module clock_gen (
    output logic o_clk
);

    // 20 ns period
    initial begin
        o_clk = 1'b0;
        forever begin
            #10 o_clk = ~o_clk;
        end
    end

endmodule

// File: tests/tb_mips_core.sv
`timescale 1ns/1ps

module tb_mips_core;

    import cpu_isa_pkg::*;
    import cpu_pipe_pkg::*;

    // 6 tests x (64 load + 5 reset + 30 run + up to 33 debug reads) is about 800
    localparam int CYCLE_LIMIT = 1000;

    logic       clk;
    logic       i_rst;
    logic       i_imem_we;
    imem_addr_t i_imem_addr;
    word_t      i_imem_data;
    reg_addr_t  i_dbg_reg;
    dmem_addr_t i_dbg_mem_addr;
    word_t      o_pc;
    word_t      o_dbg_reg_data;
    word_t      o_dbg_mem_data;

    word_t      prog [$];
    int         cycle_count;

    clock_gen u_clock_gen (
        .o_clk (clk)
    );

    mips_core u_mips_core (
        .clk            (clk),
        .i_rst          (i_rst),
        .i_imem_we      (i_imem_we),
        .i_imem_addr    (i_imem_addr),
        .i_imem_data    (i_imem_data),
        .i_dbg_reg      (i_dbg_reg),
        .i_dbg_mem_addr (i_dbg_mem_addr),
        .o_pc           (o_pc),
        .o_dbg_reg_data (o_dbg_reg_data),
        .o_dbg_mem_data (o_dbg_mem_data)
    );

    //////////////////////////////
    // Instruction encoding
    //////////////////////////////
    function automatic word_t enc_r(input logic [5:0] funct, input reg_addr_t rd,
                                    input reg_addr_t rs, input reg_addr_t rt,
                                    input shamt_t shamt);
        return {OP_RTYPE, rs, rt, rd, shamt, funct};
    endfunction

    function automatic word_t enc_i(input logic [5:0] op, input reg_addr_t rt,
                                    input reg_addr_t rs, input imm_t imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic word_t enc_j(input logic [25:0] index);
        return {OP_J, index};
    endfunction

    function automatic word_t sext(input imm_t imm);
        return {{16{imm[15]}}, imm};
    endfunction

    //////////////////////////////
    // Bus and check helpers
    //////////////////////////////
    task automatic step_cycle();
        @(posedge clk);
        #2;
    endtask

    task automatic compare_word(input word_t got, input word_t exp, input string msg);
        if (got !== exp) begin
            $display("MISMATCH at %0t ns: %s got 0x%08h expected 0x%08h",
                     $time, msg, got, exp);
            $display("TEST FAILED");
            $fatal(1, "Value check failed");
        end
    endtask

    // Debug reads settle by the falling edge
    task automatic expect_reg(input reg_addr_t idx, input word_t exp, input string msg);
        i_dbg_reg = idx;
        @(negedge clk);
        compare_word(o_dbg_reg_data, exp, msg);
        step_cycle();
    endtask

    task automatic expect_mem(input dmem_addr_t idx, input word_t exp, input string msg);
        i_dbg_mem_addr = idx;
        @(negedge clk);
        compare_word(o_dbg_mem_data, exp, msg);
        step_cycle();
    endtask

    task automatic expect_pc(input word_t exp, input string msg);
        @(negedge clk);
        compare_word(o_pc, exp, msg);
        step_cycle();
    endtask

    // Core held in reset while the program goes in, rest of memory is nop
    task automatic load_program();
        i_rst = 1'b1;
        for (int i = 0; i < IMEM_WORDS; i++) begin
            i_imem_we   = 1'b1;
            i_imem_addr = imem_addr_t'(i);
            i_imem_data = (i < prog.size()) ? prog[i] : '0;
            step_cycle();
        end
        i_imem_we = 1'b0;
        repeat (5) step_cycle();
    endtask

    task automatic run_program();
        i_rst = 1'b0;
        repeat (30) step_cycle();
    endtask

    //////////////////////////////
    // Directed tests
    //////////////////////////////
    task automatic reset_and_r0();
        prog.delete();
        prog.push_back(enc_i(OP_ADDI, 5'd0, 5'd0, 16'h1234));
        load_program();
        expect_pc(32'd0, "pc in reset");
        for (int r = 1; r < 32; r++) begin
            expect_reg(reg_addr_t'(r), 32'd0, $sformatf("r%0d after reset", r));
        end
        i_rst = 1'b0;
        @(negedge clk);
        compare_word(o_pc, 32'd0, "pc after reset release");
        step_cycle();
        repeat (29) step_cycle();
        // 30 edges out of reset, 4 bytes each
        expect_pc(32'd120, "pc after free run");
        expect_reg(5'd0, 32'd0, "r0 after addi to r0");
    endtask

    task automatic arith_chain();
        imm_t  ia;
        imm_t  ib;
        word_t e [1:10];
        ia = imm_t'($urandom);
        ib = imm_t'($urandom);
        e[1]  = sext(ia);
        e[2]  = sext(ib);
        e[3]  = e[1] + e[2];
        e[4]  = e[3] - e[1];
        e[5]  = e[4] & e[3];
        e[6]  = e[5] | e[4];
        e[7]  = e[6] ^ e[5];
        e[8]  = ~(e[7] | e[6]);
        e[9]  = ($signed(e[8]) < $signed(e[7])) ? 32'd1 : 32'd0;
        e[10] = ($signed(e[7]) < $signed(e[8])) ? 32'd1 : 32'd0;
        prog.delete();
        prog.push_back(enc_i(OP_ADDI, 5'd1, 5'd0, ia));
        prog.push_back(enc_i(OP_ADDI, 5'd2, 5'd0, ib));
        // Newest result comes from EX/MEM and the one before from MEM/WB
        // The sub reads r1 three back through the register file bypass
        prog.push_back(enc_r(FN_ADD, 5'd3, 5'd1, 5'd2, 5'd0));
        prog.push_back(enc_r(FN_SUB, 5'd4, 5'd3, 5'd1, 5'd0));
        prog.push_back(enc_r(FN_AND, 5'd5, 5'd4, 5'd3, 5'd0));
        prog.push_back(enc_r(FN_OR,  5'd6, 5'd5, 5'd4, 5'd0));
        prog.push_back(enc_r(FN_XOR, 5'd7, 5'd6, 5'd5, 5'd0));
        prog.push_back(enc_r(FN_NOR, 5'd8, 5'd7, 5'd6, 5'd0));
        prog.push_back(enc_r(FN_SLT, 5'd9, 5'd8, 5'd7, 5'd0));
        prog.push_back(enc_r(FN_SLT, 5'd10, 5'd7, 5'd8, 5'd0));
        load_program();
        run_program();
        for (int r = 1; r <= 10; r++) begin
            expect_reg(reg_addr_t'(r), e[r], $sformatf("arith chain r%0d", r));
        end
    endtask

    task automatic imm_and_shift();
        imm_t   n1;
        imm_t   n2;
        imm_t   n3;
        shamt_t s1;
        shamt_t s2;
        n1 = imm_t'($urandom) | 16'h8000;
        n2 = imm_t'($urandom) | 16'h8000;
        n3 = imm_t'($urandom) | 16'h8000;
        s1 = shamt_t'($urandom);
        s2 = shamt_t'($urandom);
        prog.delete();
        prog.push_back(enc_i(OP_ADDI, 5'd1, 5'd0, n1));
        prog.push_back(enc_i(OP_ORI,  5'd2, 5'd0, n2));
        prog.push_back(enc_i(OP_ANDI, 5'd3, 5'd1, n3));
        prog.push_back(enc_i(OP_ADDI, 5'd4, 5'd1, n2));
        prog.push_back(enc_r(FN_SLL, 5'd5, 5'd0, 5'd1, s1));
        prog.push_back(enc_r(FN_SRL, 5'd6, 5'd0, 5'd1, s2));
        load_program();
        run_program();
        expect_reg(5'd1, sext(n1), "addi sign extension");
        expect_reg(5'd2, {16'h0000, n2}, "ori zero extension");
        expect_reg(5'd3, {16'h0000, n1 & n3}, "andi zero extension");
        expect_reg(5'd4, sext(n1) + sext(n2), "addi of negative to negative");
        expect_reg(5'd5, sext(n1) << s1, "sll by shamt");
        expect_reg(5'd6, sext(n1) >> s2, "srl by shamt");
    endtask

    task automatic store_and_load();
        imm_t       v1;
        imm_t       v2;
        dmem_addr_t a1;
        dmem_addr_t a2;
        a1 = dmem_addr_t'($urandom);
        a2 = a1 + dmem_addr_t'(1 + ($urandom % 15));
        v1 = imm_t'($urandom);
        v2 = imm_t'($urandom);
        prog.delete();
        prog.push_back(enc_i(OP_ADDI, 5'd1, 5'd0, v1));
        prog.push_back(enc_i(OP_ADDI, 5'd2, 5'd0, v2));
        prog.push_back(enc_i(OP_SW, 5'd1, 5'd0, {10'b0, a1, 2'b00}));
        prog.push_back(enc_i(OP_SW, 5'd2, 5'd0, {10'b0, a2, 2'b00}));
        // One nop between each load and its use
        prog.push_back(enc_i(OP_LW, 5'd3, 5'd0, {10'b0, a1, 2'b00}));
        prog.push_back(32'd0);
        prog.push_back(enc_r(FN_ADD, 5'd4, 5'd3, 5'd3, 5'd0));
        prog.push_back(enc_i(OP_LW, 5'd5, 5'd0, {10'b0, a2, 2'b00}));
        prog.push_back(32'd0);
        prog.push_back(enc_i(OP_ADDI, 5'd6, 5'd5, 16'd1));
        load_program();
        run_program();
        expect_mem(a1, sext(v1), "stored word one");
        expect_mem(a2, sext(v2), "stored word two");
        expect_reg(5'd3, sext(v1), "lw word one");
        expect_reg(5'd4, sext(v1) + sext(v1), "use of lw word one");
        expect_reg(5'd5, sext(v2), "lw word two");
        expect_reg(5'd6, sext(v2) + 32'd1, "use of lw word two");
    endtask

    task automatic branch_slots();
        prog.delete();
        prog.push_back(enc_i(OP_ADDI, 5'd1, 5'd0, 16'd5));
        prog.push_back(enc_i(OP_ADDI, 5'd2, 5'd0, 16'd5));
        // Offset 4 lands one past the fourth slot
        prog.push_back(enc_i(OP_BEQ, 5'd2, 5'd1, 16'd4));
        prog.push_back(enc_i(OP_ADDI, 5'd3, 5'd0, 16'd1));
        prog.push_back(enc_i(OP_ADDI, 5'd4, 5'd0, 16'd2));
        prog.push_back(enc_i(OP_ADDI, 5'd5, 5'd0, 16'd3));
        prog.push_back(enc_i(OP_ADDI, 5'd6, 5'd0, 16'd4));
        prog.push_back(enc_i(OP_ADDI, 5'd7, 5'd0, 16'd5));
        prog.push_back(enc_i(OP_BNE, 5'd2, 5'd1, 16'd4));
        prog.push_back(enc_i(OP_ADDI, 5'd8, 5'd0, 16'd6));
        prog.push_back(enc_i(OP_ADDI, 5'd9, 5'd0, 16'd7));
        prog.push_back(enc_i(OP_ADDI, 5'd10, 5'd0, 16'd8));
        prog.push_back(enc_i(OP_ADDI, 5'd11, 5'd0, 16'd9));
        prog.push_back(enc_i(OP_ADDI, 5'd12, 5'd0, 16'd10));
        load_program();
        run_program();
        expect_reg(5'd3, 32'd1, "beq slot one");
        expect_reg(5'd4, 32'd2, "beq slot two");
        expect_reg(5'd5, 32'd3, "beq slot three");
        expect_reg(5'd6, 32'd0, "instruction skipped by taken beq");
        expect_reg(5'd7, 32'd5, "beq target");
        expect_reg(5'd8, 32'd6, "bne slot one");
        expect_reg(5'd9, 32'd7, "bne slot two");
        expect_reg(5'd10, 32'd8, "bne slot three");
        expect_reg(5'd11, 32'd9, "fall-through of not-taken bne");
        expect_reg(5'd12, 32'd10, "after not-taken bne");
    endtask

    task automatic jump_slots();
        prog.delete();
        prog.push_back(enc_i(OP_ADDI, 5'd1, 5'd0, 16'd11));
        prog.push_back(enc_j(26'd5));
        prog.push_back(enc_i(OP_ADDI, 5'd2, 5'd0, 16'd22));
        prog.push_back(enc_i(OP_ADDI, 5'd3, 5'd0, 16'd33));
        prog.push_back(enc_i(OP_ADDI, 5'd4, 5'd0, 16'd44));
        prog.push_back(enc_i(OP_ADDI, 5'd5, 5'd1, 16'd55));
        prog.push_back(enc_i(OP_ADDI, 5'd6, 5'd0, 16'd77));
        load_program();
        run_program();
        expect_reg(5'd2, 32'd22, "j slot one");
        expect_reg(5'd3, 32'd33, "j slot two");
        expect_reg(5'd4, 32'd0, "instruction skipped by j");
        expect_reg(5'd5, 32'd66, "j target");
        expect_reg(5'd6, 32'd77, "after j target");
    endtask

    //////////////////////////////
    // Run control
    //////////////////////////////
    initial begin
        cycle_count = 0;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("TEST FAILED");
            $fatal(1, "Timeout after %0d cycles, the tests did not finish", CYCLE_LIMIT);
        end
    end

    initial begin
        i_rst          = 1'b1;
        i_imem_we      = 1'b0;
        i_imem_addr    = '0;
        i_imem_data    = '0;
        i_dbg_reg      = '0;
        i_dbg_mem_addr = '0;
        void'($urandom(32'h92f3));
        repeat (5) step_cycle();

        arith_chain();
        imm_and_shift();
        store_and_load();
        branch_slots();
        jump_slots();
        // Registers and PC hold values from the jump program here
        reset_and_r0();

        $display("TEST OK");
        $finish;
    end

endmodule
